//--- mult_share_top.f
+incdir+src
src/res_share_pkg.sv
src/stream_pipe.sv
src/packet_arb.sv
src/mult_pipe.sv
src/resource_share.sv
src/mult_share_top.sv
test/mult_share_checker.sv
test/tb_mult_share_top.sv

//--- Bender.yml
package:
  name: mult_share

sources:
  - include_dirs:
      - src
    files:
      - src/res_share_pkg.sv
      - src/stream_pipe.sv
      - src/packet_arb.sv
      - src/mult_pipe.sv
      - src/resource_share.sv
      - src/mult_share_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/mult_share_checker.sv
      - test/tb_mult_share_top.sv

//--- test/tb_mult_share_top.sv
// Shared multiplier testbench
`timescale 1ns/1ps
`include "res_share_config.svh"

module tb_mult_share_top
  import res_share_pkg::*;
();

  localparam int N         = `RS_NUM_IN;
  localparam int N_ONE     = 12;  // Requests per client with one client active
  localparam int N_RND     = 40;  // Requests per client in mixed random traffic
  localparam int N_FAIR    = 30;  // Requests per client with everyone always valid
  localparam int N_BP      = 30;  // Requests per client under response back-pressure
  localparam int TOTAL_REQ = N * (N_ONE + N_RND + N_FAIR + N_BP);
  localparam int WDOG_CYC  = TOTAL_REQ * 40 + 200;

  logic         clk = 1'b0;
  logic         arst_n;
  req_t         req [N] = '{default: '0};
  logic [N-1:0] req_val = '0;
  logic [N-1:0] req_rdy;
  rsp_t         rsp [N];
  logic [N-1:0] rsp_val;
  logic [N-1:0] rsp_rdy = '0;
  logic         fair_on = 1'b0;

  int quota [N];                     // Requests each client may send so far
  int sent [N];                      // Requests accepted by the DUT
  int rcvd [N];                      // Responses taken from the DUT
  int val_pct = 0;                   // Chance in percent of a new request per cycle
  int rdy_pct [N] = '{default: 100}; // Chance in percent of response ready per cycle

  always #2 clk = ~clk;

  mult_share_top dut_i (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_req(req), .i_req_val(req_val), .o_req_rdy(req_rdy),
    .o_rsp(rsp), .o_rsp_val(rsp_val), .i_rsp_rdy(rsp_rdy)
  );

  mult_share_checker chk_i (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_req(req), .i_req_val(req_val), .i_req_rdy(req_rdy),
    .i_rsp(rsp), .i_rsp_val(rsp_val), .i_rsp_rdy(rsp_rdy),
    .i_fair_on(fair_on)
  );

  // Random operands, sequence number above the tag, junk in the tag bits
  function automatic req_t make_req(input int n);
    req_t r;
    r.a   = ($urandom_range(7) == 0) ? '1 : DAT_W'($urandom);  // Full scale now and then
    r.b   = DAT_W'($urandom);
    r.ctl = CTL_W'(n) << (`RS_TAG_LSB + TAG_W);
    r.ctl[`RS_TAG_LSB +: TAG_W] = TAG_W'($urandom);
    return r;
  endfunction

  // Request sources and response sinks, one per client
  always @(posedge clk) begin : drive
    int n;
    for (int c = 0; c < N; c++) begin
      n = sent[c];
      if (req_val[c] && req_rdy[c]) begin
        n = n + 1;
      end
      sent[c] <= n;
      if (!req_val[c] || req_rdy[c]) begin  // Payload held while stalled
        if (arst_n && n < quota[c] && $urandom_range(99) < val_pct) begin
          req[c]     <= make_req(n);
          req_val[c] <= 1'b1;
        end else begin
          req_val[c] <= 1'b0;
        end
      end
      if (rsp_val[c] && rsp_rdy[c]) begin
        rcvd[c] <= rcvd[c] + 1;
      end
      rsp_rdy[c] <= ($urandom_range(99) < rdy_pct[c]);
    end
  end

  task automatic start_burst(input logic [N-1:0] who, input int count, input int pct);
    @(posedge clk);
    val_pct <= pct;
    for (int c = 0; c < N; c++) begin
      if (who[c]) begin
        quota[c] <= quota[c] + count;
      end
    end
  endtask

  task automatic set_rsp_rate(input logic [N-1:0] who, input int pct);
    @(posedge clk);
    for (int c = 0; c < N; c++) begin
      if (who[c]) begin
        rdy_pct[c] <= pct;
      end
    end
  endtask

  // Done once every allowed request has come back
  task automatic wait_drained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int c = 0; c < N; c++) begin
        if (sent[c] != quota[c] || rcvd[c] != quota[c]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  initial begin : main
    int errs;
    int cmps;
    void'($urandom(32'hf242));
    arst_n = 1'b0;  // Falling edge at time zero kicks the asynchronous reset
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int c = 0; c < N; c++) begin  // One client at a time
      start_burst(N'(1) << c, N_ONE, 70);
      wait_drained();
    end
    set_rsp_rate('1, 70);
    start_burst('1, N_RND, 60);  // All clients mixed
    wait_drained();
    set_rsp_rate('1, 100);
    @(posedge clk);
    fair_on <= 1'b1;
    start_burst('1, N_FAIR, 100);  // Saturated, grants should rotate evenly
    wait_drained();
    @(posedge clk);
    fair_on <= 1'b0;
    set_rsp_rate(N'(2), 50);  // Client 1 stutters, then stalls for a long stretch
    start_burst('1, N_BP, 80);
    repeat (60) @(posedge clk);
    set_rsp_rate(N'(2), 0);
    repeat (80) @(posedge clk);
    set_rsp_rate(N'(2), 100);
    wait_drained();
    repeat (10) @(posedge clk);
    chk_i.final_check(errs, cmps);
    if (cmps != TOTAL_REQ) begin
      errs++;
      $display("Only %0d of %0d responses were compared", cmps, TOTAL_REQ);
    end
    $display("Run complete with %0d errors over %0d compared responses", errs, cmps);
    if (errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WDOG_CYC) @(posedge clk);
    $display("Timeout after %0d cycles with responses still outstanding", WDOG_CYC);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- test/mult_share_checker.sv
// Response checker for the shared multiplier
`timescale 1ns/1ps
`include "res_share_config.svh"

module mult_share_checker
  import res_share_pkg::*;
#(
  parameter int NUM_IN = `RS_NUM_IN
) (
  input logic              i_clk,
  input logic              i_arst_n,
  input req_t              i_req [NUM_IN],  // Client requests as driven into the DUT
  input logic [NUM_IN-1:0] i_req_val,
  input logic [NUM_IN-1:0] i_req_rdy,
  input rsp_t              i_rsp [NUM_IN],  // Client responses leaving the DUT
  input logic [NUM_IN-1:0] i_rsp_val,
  input logic [NUM_IN-1:0] i_rsp_rdy,
  input logic              i_fair_on        // Grant counts must stay level while high
);

  rsp_t exp_q [NUM_IN][$];   // Expected responses per client, oldest first
  int   acc_cnt [NUM_IN];    // Accepted requests since the fairness window opened
  int   err_cnt  = 0;
  int   cmp_cnt  = 0;
  logic seen_req = 1'b0;     // Any request accepted since reset
  logic fair_bad = 1'b0;     // Imbalance already reported in this window

  // Product of the operands, control word kept with the tag bits zeroed
  function automatic rsp_t expect_rsp(input req_t r);
    rsp_t             e;
    logic [CTL_W-1:0] tag_mask;
    tag_mask = CTL_W'((1 << TAG_W) - 1) << `RS_TAG_LSB;
    e.prod   = PROD_W'(r.a) * PROD_W'(r.b);
    e.ctl    = r.ctl & ~tag_mask;
    return e;
  endfunction

  // Inputs change on the rising edge, so the falling edge sees settled handshakes
  always @(negedge i_clk) begin : compare
    rsp_t exp;
    int   lo;
    int   hi;
    if (!i_arst_n) begin
      seen_req = 1'b0;
    end
    if (!seen_req && i_rsp_val != '0) begin
      err_cnt++;
      $display("ERR %0t response valid %b raised with no request accepted", $time, i_rsp_val);
    end
    for (int c = 0; c < NUM_IN; c++) begin
      if (i_arst_n && i_req_val[c] && i_req_rdy[c]) begin
        exp_q[c].push_back(expect_rsp(i_req[c]));
        seen_req = 1'b1;
        acc_cnt[c]++;
      end
      if (i_arst_n && i_rsp_val[c] && i_rsp_rdy[c]) begin
        if (exp_q[c].size() == 0) begin
          err_cnt++;
          $display("ERR %0t client %0d got prod %h ctl %h with nothing outstanding",
                   $time, c, i_rsp[c].prod, i_rsp[c].ctl);
        end else begin
          exp = exp_q[c].pop_front();
          cmp_cnt++;
          if (i_rsp[c] !== exp) begin
            err_cnt++;
            $display("ERR %0t client %0d got prod %h ctl %h, expected prod %h ctl %h",
                     $time, c, i_rsp[c].prod, i_rsp[c].ctl, exp.prod, exp.ctl);
          end
        end
      end
    end
    if (i_fair_on) begin
      lo = acc_cnt[0];
      hi = acc_cnt[0];
      for (int c = 1; c < NUM_IN; c++) begin
        lo = (acc_cnt[c] < lo) ? acc_cnt[c] : lo;
        hi = (acc_cnt[c] > hi) ? acc_cnt[c] : hi;
      end
      if (hi - lo > 1 && !fair_bad) begin  // One report per window is enough
        err_cnt++;
        fair_bad = 1'b1;
        $display("ERR %0t grant counts drifted apart, low %0d high %0d", $time, lo, hi);
      end
    end else begin
      fair_bad = 1'b0;
      for (int c = 0; c < NUM_IN; c++) begin
        acc_cnt[c] = 0;
      end
    end
  end

  // Leftover expectations mean responses went missing
  task automatic final_check(output int errs, output int cmps);
    for (int c = 0; c < NUM_IN; c++) begin
      if (exp_q[c].size() != 0) begin
        err_cnt++;
        $display("Client %0d never received %0d of its responses", c, exp_q[c].size());
      end
    end
    errs = err_cnt;
    cmps = cmp_cnt;
  endtask

endmodule

//--- src/mult_share_top.sv
// Multiplier shared among clients
`timescale 1ns/1ps
`include "res_share_config.svh"

module mult_share_top
  import res_share_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_arst_n,
  input  req_t                  i_req [`RS_NUM_IN],
  input  logic [`RS_NUM_IN-1:0] i_req_val,
  output logic [`RS_NUM_IN-1:0] o_req_rdy,
  output rsp_t                  o_rsp [`RS_NUM_IN],
  output logic [`RS_NUM_IN-1:0] o_rsp_val,
  input  logic [`RS_NUM_IN-1:0] i_rsp_rdy
);

  req_t mul_req;  // Arbiter to multiplier
  logic mul_req_val;
  logic mul_req_rdy;
  rsp_t mul_rsp;  // Multiplier back to the demux
  logic mul_rsp_val;
  logic mul_rsp_rdy;

  resource_share #(
    .NUM_IN  (`RS_NUM_IN),
    .TAG_LSB (`RS_TAG_LSB),
    .PIPE_IN (`RS_PIPE_IN),
    .PIPE_OUT(`RS_PIPE_OUT),
    .PRIORITY(`RS_PRIORITY)
  ) share_i (
    .i_clk, .i_arst_n,
    .i_req, .i_req_val, .o_req_rdy,
    .o_res(mul_req), .o_res_val(mul_req_val), .i_res_rdy(mul_req_rdy),
    .i_res(mul_rsp), .i_res_val(mul_rsp_val), .o_res_rdy(mul_rsp_rdy),
    .o_rsp, .o_rsp_val, .i_rsp_rdy
  );

  mult_pipe mult_i (
    .i_clk, .i_arst_n,
    .i_req(mul_req), .i_val(mul_req_val), .o_rdy(mul_req_rdy),
    .o_rsp(mul_rsp), .o_val(mul_rsp_val), .i_rdy(mul_rsp_rdy)
  );

endmodule

//--- src/resource_share.sv
// Arbitration and tag demux around a shared resource
`timescale 1ns/1ps
`include "res_share_config.svh"

module resource_share
  import res_share_pkg::*;
#(
  parameter int NUM_IN   = `RS_NUM_IN,
  parameter int TAG_LSB  = `RS_TAG_LSB,
  parameter int PIPE_IN  = `RS_PIPE_IN,
  parameter int PIPE_OUT = `RS_PIPE_OUT,
  parameter int PRIORITY = `RS_PRIORITY
) (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  req_t              i_req [NUM_IN],  // Client requests
  input  logic [NUM_IN-1:0] i_req_val,
  output logic [NUM_IN-1:0] o_req_rdy,
  output req_t              o_res,           // Tagged request to the resource
  output logic              o_res_val,
  input  logic              i_res_rdy,
  input  rsp_t              i_res,           // Tagged response from the resource
  input  logic              i_res_val,
  output logic              o_res_rdy,
  output rsp_t              o_rsp [NUM_IN],  // Client responses
  output logic [NUM_IN-1:0] o_rsp_val,
  input  logic [NUM_IN-1:0] i_rsp_rdy
);

  req_t              arb_req [NUM_IN];  // Input pipes into the arbiter
  logic [NUM_IN-1:0] arb_val;
  logic [NUM_IN-1:0] arb_rdy;
  rsp_t              dmx_rsp [NUM_IN];  // Demux outputs into the output pipes
  logic [NUM_IN-1:0] dmx_val;
  logic [NUM_IN-1:0] dmx_rdy;
  logic [TAG_W-1:0]  sel;               // Client that owns the current response

  assign sel = i_res.ctl[TAG_LSB +: TAG_W];

  for (genvar g = 0; g < NUM_IN; g++) begin : g_client
    stream_pipe #(.payload_t(req_t), .NUM_STAGES(PIPE_IN)) in_pipe_i (
      .i_clk, .i_arst_n,
      .i_dat(i_req[g]), .i_val(i_req_val[g]), .o_rdy(o_req_rdy[g]),
      .o_dat(arb_req[g]), .o_val(arb_val[g]), .i_rdy(arb_rdy[g])
    );

    // Copy the response to every client, valid only where the tag matches
    always_comb begin
      dmx_rsp[g] = i_res;
      dmx_rsp[g].ctl[TAG_LSB +: TAG_W] = '0;  // Client never sees its tag
      dmx_val[g] = i_res_val && (sel == TAG_W'(g));
    end

    stream_pipe #(.payload_t(rsp_t), .NUM_STAGES(PIPE_OUT)) out_pipe_i (
      .i_clk, .i_arst_n,
      .i_dat(dmx_rsp[g]), .i_val(dmx_val[g]), .o_rdy(dmx_rdy[g]),
      .o_dat(o_rsp[g]), .o_val(o_rsp_val[g]), .i_rdy(i_rsp_rdy[g])
    );
  end

  packet_arb #(.NUM_IN(NUM_IN), .PRIORITY(PRIORITY)) arb_i (
    .i_clk, .i_arst_n,
    .i_req(arb_req), .i_val(arb_val), .o_rdy(arb_rdy),
    .o_req(o_res), .o_val(o_res_val), .i_rdy(i_res_rdy)
  );

  // A stalled owner stalls the resource; a tag past the last client is never ready
  assign o_res_rdy = (int'(sel) < NUM_IN) ? dmx_rdy[sel] : 1'b0;

endmodule

//--- src/mult_pipe.sv
// Pipelined shared multiplier
`timescale 1ns/1ps
`include "res_share_config.svh"

module mult_pipe
  import res_share_pkg::*;
(
  input  logic i_clk,
  input  logic i_arst_n,
  input  req_t i_req,
  input  logic i_val,
  output logic o_rdy,
  output rsp_t o_rsp,
  output logic o_val,
  input  logic i_rdy
);

  localparam int STAGES = `RS_MUL_STAGES;
  localparam int HALF   = DAT_W / 2;     // Split point of operand b
  localparam int PP_W   = DAT_W + HALF;  // Width of one partial product
  localparam int TAIL   = STAGES - 1;    // Stages after the partial products

  logic             en;          // Single enable for every stage
  logic             pp_val_q;
  logic [PP_W-1:0]  pp_lo_q;     // a times the low half of b
  logic [PP_W-1:0]  pp_hi_q;     // a times the high half of b
  logic [CTL_W-1:0] pp_ctl_q;
  rsp_t             tail_q [TAIL];
  logic [TAIL-1:0]  tail_val_q;

  // The whole pipe freezes while its last stage is full and not taken
  assign en    = ~tail_val_q[TAIL-1] | i_rdy;
  assign o_rdy = en;
  assign o_rsp = tail_q[TAIL-1];
  assign o_val = tail_val_q[TAIL-1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pp_val_q   <= 1'b0;
      tail_val_q <= '0;
    end else if (en) begin
      pp_val_q      <= i_val;
      tail_val_q[0] <= pp_val_q;
      for (int k = 1; k < TAIL; k++) begin
        tail_val_q[k] <= tail_val_q[k-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (en) begin
      // First stage forms two narrow partial products
      pp_lo_q  <= i_req.a * i_req.b[HALF-1:0];
      pp_hi_q  <= i_req.a * i_req.b[DAT_W-1:HALF];
      pp_ctl_q <= i_req.ctl;
      // Second stage adds them back up with the high half shifted
      tail_q[0].prod <= PROD_W'(pp_lo_q) + (PROD_W'(pp_hi_q) << HALF);
      tail_q[0].ctl  <= pp_ctl_q;
      for (int k = 1; k < TAIL; k++) begin
        tail_q[k] <= tail_q[k-1];  // Extra latency stages just delay
      end
    end
  end

endmodule

//--- src/packet_arb.sv
// Request arbiter with tag insertion
`timescale 1ns/1ps
`include "res_share_config.svh"

module packet_arb
  import res_share_pkg::*;
#(
  parameter int NUM_IN   = `RS_NUM_IN,
  parameter int PRIORITY = `RS_PRIORITY
) (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  req_t              i_req [NUM_IN],
  input  logic [NUM_IN-1:0] i_val,
  output logic [NUM_IN-1:0] o_rdy,
  output req_t              o_req,
  output logic              o_val,
  input  logic              i_rdy
);

  logic             take;     // Output register free or being emptied
  logic             win_val;  // Some client is asking this cycle
  logic [TAG_W-1:0] win_idx;  // Index of the chosen client
  logic [TAG_W-1:0] last_q;   // Last granted client for round robin
  req_t             win_req;  // Winner request with its tag written in

  assign take = ~o_val | i_rdy;

  // The loop runs from the weakest candidate to the strongest
  // so the last hit is the one that wins
  always_comb begin : pick
    int idx;
    win_val = 1'b0;
    win_idx = '0;
    idx     = 0;
    for (int i = NUM_IN; i > 0; i--) begin
      if (PRIORITY != 0) begin
        idx = i - 1;  // Lowest index checked last
      end else begin
        idx = (int'(last_q) + i) % NUM_IN;  // Last winner itself comes first
      end
      if (i_val[idx]) begin
        win_val = 1'b1;
        win_idx = TAG_W'(idx);
      end
    end
  end

  // Stamp the client index into the control word
  always_comb begin
    win_req = i_req[win_idx];
    win_req.ctl[`RS_TAG_LSB +: TAG_W] = win_idx;
  end

  // Only the granted client sees ready
  always_comb begin
    o_rdy = '0;
    if (take && win_val) begin
      o_rdy[win_idx] = 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_val  <= 1'b0;
      last_q <= '0;
    end else if (take) begin
      o_val <= win_val;  // Clears when the held beat leaves and nobody asks
      if (win_val) begin
        last_q <= win_idx;
      end
    end
  end

  // Payload register, loads only on a grant
  always_ff @(posedge i_clk) begin
    if (take && win_val) begin
      o_req <= win_req;
    end
  end

endmodule

//--- src/stream_pipe.sv
// Valid/ready register chain
`timescale 1ns/1ps

module stream_pipe #(
  parameter type payload_t  = logic,
  parameter int  NUM_STAGES = 1
) (
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  payload_t i_dat,
  input  logic     i_val,
  output logic     o_rdy,
  output payload_t o_dat,
  output logic     o_val,
  input  logic     i_rdy
);

  if (NUM_STAGES == 0) begin : g_wire
    // No registers asked for, so the stream passes straight across
    assign o_dat = i_dat;
    assign o_val = i_val;
    assign o_rdy = i_rdy;
  end else begin : g_regs
    payload_t              dat_q [NUM_STAGES];  // Stage payloads, no reset
    logic [NUM_STAGES-1:0] val_q;               // Stage full flags
    logic [NUM_STAGES-1:0] stg_rdy;             // Stage can load this cycle

    assign o_rdy = stg_rdy[0];
    assign o_dat = dat_q[NUM_STAGES-1];
    assign o_val = val_q[NUM_STAGES-1];

    for (genvar g = 0; g < NUM_STAGES; g++) begin : g_stage
      payload_t in_dat;  // What the stage would load
      logic     in_val;
      logic     out_rdy;  // Ready seen from the next stage down

      if (g == 0) begin : g_first
        assign in_dat = i_dat;
        assign in_val = i_val;
      end else begin : g_mid
        assign in_dat = dat_q[g-1];
        assign in_val = val_q[g-1];
      end

      if (g == NUM_STAGES - 1) begin : g_last
        assign out_rdy = i_rdy;
      end else begin : g_inner
        assign out_rdy = stg_rdy[g+1];
      end

      // An empty stage always loads, a full one only as it drains
      assign stg_rdy[g] = ~val_q[g] | out_rdy;

      always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          val_q[g] <= 1'b0;
        end else if (stg_rdy[g]) begin
          val_q[g] <= in_val;  // Drops to empty when nothing arrives behind
        end
      end

      always_ff @(posedge i_clk) begin
        if (stg_rdy[g] && in_val) begin
          dat_q[g] <= in_dat;
        end
      end
    end
  end

endmodule

//--- src/res_share_pkg.sv
// Shared multiplier types
`include "res_share_config.svh"

package res_share_pkg;

  localparam int DAT_W  = `RS_DAT_BITS;   // Operand width
  localparam int CTL_W  = `RS_CTL_BITS;   // Control word width
  localparam int PROD_W = 2 * DAT_W;      // Full product width

  // Tag width follows the client count, never below one bit
  localparam int TAG_W = (`RS_NUM_IN > 1) ? $clog2(`RS_NUM_IN) : 1;

  // One request beat toward the multiplier
  typedef struct packed {
    logic [DAT_W-1:0] a;    // First operand
    logic [DAT_W-1:0] b;    // Second operand
    logic [CTL_W-1:0] ctl;  // Carried through untouched apart from the tag
  } req_t;

  // One response beat coming back from the multiplier
  typedef struct packed {
    logic [PROD_W-1:0] prod;  // a times b
    logic [CTL_W-1:0]  ctl;   // Control word of the matching request
  } rsp_t;

endpackage

//--- src/res_share_config.svh
// Shared multiplier configuration
`ifndef RES_SHARE_CONFIG_SVH
`define RES_SHARE_CONFIG_SVH

// Number of clients sharing the multiplier
`define RS_NUM_IN 4

// Width of each multiplier operand
`define RS_DAT_BITS 16

// Width of the control word that travels with every request
`define RS_CTL_BITS 8

// Lowest bit of the client tag inside the control word
`define RS_TAG_LSB 0

// Multiplier latency in cycles, must be 2 or more
`define RS_MUL_STAGES 3

// Register stages in front of the arbiter, per client
`define RS_PIPE_IN 1

// Register stages after the tag demux, per client
`define RS_PIPE_OUT 1

// 0 gives round robin, 1 gives fixed priority with the lowest index first
`define RS_PRIORITY 0

`endif
